/* design/core_pkg.sv */
package core_pkg;

   localparam int XLEN       = 32;
   localparam int NREG       = 32;
   localparam int REG_AW     = $clog2(NREG);
   localparam int DMEM_WORDS = 256;
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_SLT  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LW   = 4'd7,
      OP_LH   = 4'd8,
      OP_LB   = 4'd9,
      OP_SW   = 4'd10,
      OP_SH   = 4'd11,
      OP_SB   = 4'd12,
      OP_BEQ  = 4'd13
   } op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   typedef enum logic {
      PIPE_GO    = 1'b0,
      PIPE_FLUSH = 1'b1
   } pipe_cmd_e;

   typedef struct packed {
      op_e                op;
      logic [REG_AW-1:0]  rs;
      logic [REG_AW-1:0]  rt;
      logic [REG_AW-1:0]  rd;
      logic signed [15:0] imm;
   } issue_t;

   typedef struct packed {
      logic              valid;
      op_e               op;
      logic [REG_AW-1:0] rs;
      logic [REG_AW-1:0] rt;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   rs_val;
      logic [XLEN-1:0]   rt_val;
      logic [XLEN-1:0]   imm32;
      logic              mem_rd;
      logic              mem_wr;
      logic              reg_wr;
      logic              use_rt;
      size_e             size;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] rd;
      logic              reg_wr;
      logic              mem_rd;
      logic              mem_wr;
      size_e             size;
      logic [XLEN-1:0]   alu_res;
      logic [XLEN-1:0]   store_data;
   } ex_mem_t;

   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] rd;
      logic              reg_wr;
      logic [XLEN-1:0]   data;
   } mem_wb_t;

   typedef struct packed {
      logic              valid;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   data;
   } wb_t;

   // Ops that read rt as a second source.
   function automatic logic uses_rt(input op_e op);
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: return 1'b1;
         OP_SW, OP_SH, OP_SB, OP_BEQ:           return 1'b1;
         default:                               return 1'b0;
      endcase
   endfunction

endpackage

/* design/pipe_reg.sv */
module pipe_reg import core_pkg::*; #(
   parameter type payload_t = logic
) (
   input  logic      clk,
   input  logic      rst,
   input  pipe_cmd_e cmd,
   input  payload_t  d,
   output payload_t  q
);

   // An all-zero payload is a bubble, valid and all write enables low.
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         q <= '0;
      end else if (cmd == PIPE_FLUSH) begin
         q <= '0;
      end else begin
         q <= d;
      end
   end

endmodule

/* design/operand_fetch.sv */
module operand_fetch import core_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  issue_t  issue_op,
   input  logic    accept,
   input  mem_wb_t wr,
   output id_ex_t  id_ex
);

   logic [XLEN-1:0] regs [NREG];
   logic            wr_en;
   logic [XLEN-1:0] rs_val;
   logic [XLEN-1:0] rt_val;

   // reg_wr is never set for r0, so entry 0 stays zero after reset.
   assign wr_en = wr.valid && wr.reg_wr && (wr.rd != '0);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // Write-through from the port that writes this edge.
   assign rs_val = (issue_op.rs == '0) ? '0 :
                   (wr_en && wr.rd == issue_op.rs) ? wr.data : regs[issue_op.rs];
   assign rt_val = (issue_op.rt == '0) ? '0 :
                   (wr_en && wr.rd == issue_op.rt) ? wr.data : regs[issue_op.rt];

   always_comb begin
      id_ex = '0;
      if (accept) begin
         id_ex.valid  = 1'b1;
         id_ex.op     = issue_op.op;
         id_ex.rs     = issue_op.rs;
         id_ex.rt     = issue_op.rt;
         id_ex.rd     = issue_op.rd;
         id_ex.rs_val = rs_val;
         id_ex.rt_val = rt_val;
         id_ex.imm32  = {{(XLEN-16){issue_op.imm[15]}}, issue_op.imm};
         id_ex.use_rt = uses_rt(issue_op.op);
         id_ex.size   = SZ_WORD;
         case (issue_op.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT, OP_ADDI: id_ex.reg_wr = 1'b1;
            OP_LW, OP_LH, OP_LB: begin
               id_ex.mem_rd = 1'b1;
               id_ex.reg_wr = 1'b1;
            end
            OP_SW, OP_SH, OP_SB: id_ex.mem_wr = 1'b1;
            default: ;
         endcase
         if (issue_op.op == OP_LH || issue_op.op == OP_SH) begin
            id_ex.size = SZ_HALF;
         end else if (issue_op.op == OP_LB || issue_op.op == OP_SB) begin
            id_ex.size = SZ_BYTE;
         end
         // Writes to r0 are dropped here.
         id_ex.reg_wr = id_ex.reg_wr && (issue_op.rd != '0);
      end
   end

endmodule

/* design/hazard_ctrl.sv */
module hazard_ctrl import core_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      issue_valid,
   input  issue_t    issue_op,
   input  id_ex_t    id_ex,
   input  logic      branch_taken,
   output logic      issue_ready,
   output logic      accept,
   output pipe_cmd_e id_ex_cmd
);

   logic load_in_ex;
   logic rs_hit;
   logic rt_hit;
   logic load_use;
   logic squash;
   logic squash_pending;

   // A load's data only appears after the memory read.
   assign load_in_ex = id_ex.valid && id_ex.mem_rd && id_ex.reg_wr;
   assign rs_hit     = (issue_op.op != OP_NOP) && (issue_op.rs == id_ex.rd);
   assign rt_hit     = uses_rt(issue_op.op) && (issue_op.rt == id_ex.rd);
   assign load_use   = issue_valid && load_in_ex && (rs_hit || rt_hit);

   assign issue_ready = !load_use;
   assign accept      = issue_valid && issue_ready;

   // First op accepted after a taken beq, same edge or later.
   assign squash    = accept && (squash_pending || branch_taken);
   assign id_ex_cmd = (load_use || squash) ? PIPE_FLUSH : PIPE_GO;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         squash_pending <= 1'b0;
      end else begin
         squash_pending <= (squash_pending || branch_taken) && !accept;
      end
   end

endmodule

/* design/exec_stage.sv */
module exec_stage import core_pkg::*; (
   input  id_ex_t  id_ex,
   input  ex_mem_t ex_mem_fwd,
   input  mem_wb_t mem_wb_fwd,
   output ex_mem_t ex_mem,
   output logic    branch_taken
);

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;

   // Youngest writer wins. Loads in EX/MEM never match, the stall
   // keeps them one op away. reg_wr already implies rd != 0.
   function automatic logic [XLEN-1:0] fwd(
      input logic [REG_AW-1:0] src,
      input logic [XLEN-1:0]   val,
      input ex_mem_t           em,
      input mem_wb_t           mw
   );
      if (em.valid && em.reg_wr && !em.mem_rd && em.rd == src) begin
         return em.alu_res;
      end else if (mw.valid && mw.reg_wr && mw.rd == src) begin
         return mw.data;
      end
      return val;
   endfunction

   assign op_a = fwd(id_ex.rs, id_ex.rs_val, ex_mem_fwd, mem_wb_fwd);
   assign op_b = fwd(id_ex.rt, id_ex.rt_val, ex_mem_fwd, mem_wb_fwd);

   always_comb begin
      case (id_ex.op)
         OP_ADD: alu_res = op_a + op_b;
         OP_SUB: alu_res = op_a - op_b;
         OP_AND: alu_res = op_a & op_b;
         OP_OR:  alu_res = op_a | op_b;
         OP_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         // Addi and all memory ops use rs + imm.
         OP_ADDI, OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB: begin
            alu_res = op_a + id_ex.imm32;
         end
         default: alu_res = '0;
      endcase
   end

   assign branch_taken = id_ex.valid && (id_ex.op == OP_BEQ) && (op_a == op_b);

   always_comb begin
      ex_mem.valid      = id_ex.valid;
      ex_mem.rd         = id_ex.rd;
      ex_mem.reg_wr     = id_ex.reg_wr;
      ex_mem.mem_rd     = id_ex.mem_rd;
      ex_mem.mem_wr     = id_ex.mem_wr;
      ex_mem.size       = id_ex.size;
      ex_mem.alu_res    = alu_res;
      ex_mem.store_data = op_b;
   end

endmodule

/* design/mem_stage.sv */
module mem_stage import core_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  ex_mem_t ex_mem,
   output mem_wb_t mem_wb
);

   logic [XLEN-1:0]    mem [DMEM_WORDS];
   logic [DMEM_AW-1:0] word_idx;
   logic [1:0]         lane;
   logic [3:0]         byte_en;
   logic [XLEN-1:0]    wdata;
   logic [XLEN-1:0]    shifted;
   logic [XLEN-1:0]    load_val;

   // Address wraps within the memory.
   assign word_idx = ex_mem.alu_res[2 +: DMEM_AW];

   // Half accesses ignore address bit 0, word accesses bits 1:0.
   always_comb begin
      case (ex_mem.size)
         SZ_BYTE: begin
            lane    = ex_mem.alu_res[1:0];
            byte_en = 4'b0001 << lane;
         end
         SZ_HALF: begin
            lane    = {ex_mem.alu_res[1], 1'b0};
            byte_en = 4'b0011 << lane;
         end
         default: begin
            lane    = 2'b00;
            byte_en = 4'b1111;
         end
      endcase
   end

   assign wdata = ex_mem.store_data << {lane, 3'b000};

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (ex_mem.valid && ex_mem.mem_wr) begin
         for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
               mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
   end

   // Sign-extend the selected lane.
   assign shifted = mem[word_idx] >> {lane, 3'b000};

   always_comb begin
      case (ex_mem.size)
         SZ_BYTE: load_val = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
         SZ_HALF: load_val = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
         default: load_val = shifted;
      endcase
   end

   always_comb begin
      mem_wb.valid  = ex_mem.valid;
      mem_wb.rd     = ex_mem.rd;
      mem_wb.reg_wr = ex_mem.reg_wr;
      mem_wb.data   = ex_mem.mem_rd ? load_val : ex_mem.alu_res;
   end

endmodule

/* design/backend_top.sv */
module backend_top import core_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   issue_valid,
   input  issue_t issue_op,
   output logic   issue_ready,
   output wb_t    wb
);

   id_ex_t    id_ex_d;
   id_ex_t    id_ex_q;
   ex_mem_t   ex_mem_d;
   ex_mem_t   ex_mem_q;
   mem_wb_t   mem_wb_d;
   mem_wb_t   mem_wb_q;
   pipe_cmd_e id_ex_cmd;
   logic      accept;
   logic      branch_taken;

   operand_fetch u_fetch (
      .clk      (clk),
      .rst      (rst),
      .issue_op (issue_op),
      .accept   (accept),
      .wr       (mem_wb_q),
      .id_ex    (id_ex_d)
   );

   hazard_ctrl u_hazard (
      .clk          (clk),
      .rst          (rst),
      .issue_valid  (issue_valid),
      .issue_op     (issue_op),
      .id_ex        (id_ex_q),
      .branch_taken (branch_taken),
      .issue_ready  (issue_ready),
      .accept       (accept),
      .id_ex_cmd    (id_ex_cmd)
   );

   pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
      .clk (clk),
      .rst (rst),
      .cmd (id_ex_cmd),
      .d   (id_ex_d),
      .q   (id_ex_q)
   );

   exec_stage u_exec (
      .id_ex        (id_ex_q),
      .ex_mem_fwd   (ex_mem_q),
      .mem_wb_fwd   (mem_wb_q),
      .ex_mem       (ex_mem_d),
      .branch_taken (branch_taken)
   );

   // Later stages never flush.
   pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
      .clk (clk),
      .rst (rst),
      .cmd (PIPE_GO),
      .d   (ex_mem_d),
      .q   (ex_mem_q)
   );

   mem_stage u_mem (
      .clk    (clk),
      .rst    (rst),
      .ex_mem (ex_mem_q),
      .mem_wb (mem_wb_d)
   );

   pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
      .clk (clk),
      .rst (rst),
      .cmd (PIPE_GO),
      .d   (mem_wb_d),
      .q   (mem_wb_q)
   );

   assign wb.valid = mem_wb_q.valid && mem_wb_q.reg_wr;
   assign wb.rd    = mem_wb_q.rd;
   assign wb.data  = mem_wb_q.data;

endmodule

/* verification/backend_assert.sv */
module backend_assert import core_pkg::*; (
   input logic clk,
   input logic rst,
   input logic issue_ready,
   input wb_t  wb
);

   // A load-use stall lasts exactly one cycle.
   property ready_recovers;
      @(posedge clk) disable iff (!rst) !issue_ready |=> issue_ready;
   endproperty

   property no_r0_report;
      @(posedge clk) disable iff (!rst) wb.valid |-> (wb.rd != '0);
   endproperty

   // Ready out of reset.
   property ready_after_reset;
      @(posedge clk) $rose(rst) |-> issue_ready;
   endproperty

   ready_recovers_chk: assert property (ready_recovers)
      else $error("issue_ready was low for two cycles in a row");

   no_r0_report_chk: assert property (no_r0_report)
      else $error("writeback reported register 0");

   ready_after_reset_chk: assert property (ready_after_reset)
      else $error("issue_ready low in the cycle after reset release");

endmodule

bind backend_top backend_assert u_assert (
   .clk         (clk),
   .rst         (rst),
   .issue_ready (issue_ready),
   .wb          (wb)
);

/* verification/backend_tb.sv */
module backend_tb import core_pkg::*;;

   localparam int NUM_OPS      = 2000;
   localparam int ACCEPT_LIMIT = 8;
   localparam int DRAIN_LIMIT  = 20;

   logic   clk = 1'b0;
   logic   rst;
   logic   issue_valid;
   issue_t issue_op;
   logic   issue_ready;
   wb_t    wb;

   integer      seed = 80;
   logic [31:0] model_regs [NREG];
   logic [7:0]  model_mem [4*DMEM_WORDS];
   logic        skip_next;
   logic [4:0]  load_rd;
   wb_t         expected_q [$];
   wb_t         head_wb;
   int          wb_count;
   int          taken_count;
   int          stall_count;

   backend_top UUT (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_ready (issue_ready),
      .wb          (wb)
   );

   always #10 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic expect_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                             $time, what, got, exp));
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // A load sitting in ID/EX stalls an op that reads its rd.
   function automatic logic load_use_expected(input issue_t op);
      logic reads_rt;
      reads_rt = op.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT,
                               OP_SW, OP_SH, OP_SB, OP_BEQ};
      if (load_rd == '0 || op.op == OP_NOP) begin
         return 1'b0;
      end
      return (op.rs == load_rd) || (reads_rt && op.rt == load_rd);
   endfunction

   // Weighted op mix over r0..r7 so that hazards are frequent.
   task automatic pick_issue(output issue_t op);
      int pick;
      pick   = rand_below(100);
      op     = '0;
      op.rs  = 5'(rand_below(8));
      op.rt  = 5'(rand_below(8));
      op.rd  = 5'(rand_below(8));
      op.imm = 16'(rand_below(65536));
      if (pick < 30) begin
         op.op = op_e'(4'(1 + rand_below(5)));
      end else if (pick < 42) begin
         op.op = OP_ADDI;
      end else if (pick < 82) begin
         if (pick < 62) begin
            op.op = op_e'(4'(7 + rand_below(3)));
         end else begin
            op.op = op_e'(4'(10 + rand_below(3)));
         end
         // Small addresses so loads hit earlier stores.
         op.imm = 16'(rand_below(64));
         if (rand_below(2) == 0) begin
            op.rs = '0;
         end
      end else if (pick < 95) begin
         op.op = OP_BEQ;
         if (rand_below(2) == 0) begin
            op.rt = op.rs;
         end
      end else begin
         op.op = OP_NOP;
      end
   endtask

   // Sequential architectural model, little-endian byte memory.
   task automatic run_model(input issue_t op);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [31:0] res;
      logic        writes;
      logic [9:0]  ba;
      wb_t         exp_wb;
      load_rd = '0;
      if (skip_next) begin
         skip_next = 1'b0;
         return;
      end
      if (op.op inside {OP_LW, OP_LH, OP_LB}) begin
         load_rd = op.rd;
      end
      a      = model_regs[op.rs];
      b      = model_regs[op.rt];
      addr   = a + {{16{op.imm[15]}}, op.imm};
      ba     = addr[9:0];
      res    = '0;
      writes = 1'b1;
      case (op.op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_ADDI: res = addr;
         OP_LW: begin
            ba[1:0] = 2'b00;
            res = {model_mem[ba + 10'd3], model_mem[ba + 10'd2],
                   model_mem[ba + 10'd1], model_mem[ba]};
         end
         OP_LH: begin
            ba[0] = 1'b0;
            res = {{16{model_mem[ba + 10'd1][7]}}, model_mem[ba + 10'd1], model_mem[ba]};
         end
         OP_LB: res = {{24{model_mem[ba][7]}}, model_mem[ba]};
         default: writes = 1'b0;
      endcase
      if (op.op == OP_SW) begin
         ba[1:0] = 2'b00;
         for (int i = 0; i < 4; i++) begin
            model_mem[ba + 10'(i)] = b[8*i +: 8];
         end
      end else if (op.op == OP_SH) begin
         ba[0] = 1'b0;
         model_mem[ba]         = b[7:0];
         model_mem[ba + 10'd1] = b[15:8];
      end else if (op.op == OP_SB) begin
         model_mem[ba] = b[7:0];
      end else if (op.op == OP_BEQ && a == b) begin
         skip_next = 1'b1;
         taken_count++;
      end
      // r0 is never written and never reported.
      if (writes && op.rd != '0) begin
         model_regs[op.rd] = res;
         exp_wb.valid = 1'b1;
         exp_wb.rd    = op.rd;
         exp_wb.data  = res;
         expected_q.push_back(exp_wb);
      end
   endtask

   // Present one op and hold it until it is accepted.
   task automatic drive_issue(input issue_t op);
      int waited;
      waited = 0;
      issue_valid <= 1'b1;
      issue_op    <= op;
      @(negedge clk);
      expect_equal("issue_ready", 32'(issue_ready), 32'(!load_use_expected(op)));
      while (!issue_ready && waited < ACCEPT_LIMIT) begin
         stall_count++;
         waited++;
         load_rd = '0;
         @(negedge clk);
      end
      if (!issue_ready) begin
         abort_run("issue_ready stayed low, the operation was never accepted");
      end else begin
         @(posedge clk);
         run_model(op);
      end
   endtask

   always @(negedge clk) begin
      if (rst && wb.valid) begin
         if (expected_q.size() == 0) begin
            abort_run("a writeback was reported that the model did not expect");
         end else begin
            head_wb = expected_q.pop_front();
            expect_equal("wb.rd", 32'(wb.rd), 32'(head_wb.rd));
            expect_equal("wb.data", wb.data, head_wb.data);
            wb_count++;
         end
      end
   end

   initial begin
      issue_t next_op;
      int     gap;
      int     waited;
      rst         = 1'b0;
      issue_valid = 1'b0;
      issue_op    = '0;
      skip_next   = 1'b0;
      load_rd     = '0;
      wb_count    = 0;
      taken_count = 0;
      stall_count = 0;
      for (int i = 0; i < NREG; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < 4*DMEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      repeat (5) @(posedge clk);
      rst <= 1'b1;
      for (int n = 0; n < NUM_OPS; n++) begin
         pick_issue(next_op);
         drive_issue(next_op);
         gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
         if (gap > 0) begin
            issue_valid <= 1'b0;
            load_rd = '0;
            repeat (gap) @(posedge clk);
         end
      end
      issue_valid <= 1'b0;
      waited = 0;
      while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      // A few idle cycles to catch stray writebacks.
      repeat (4) @(posedge clk);
      $display("%0d writebacks checked, %0d taken branches, %0d stall cycles",
               wb_count, taken_count, stall_count);
      if (expected_q.size() != 0) begin
         abort_run("expected writebacks were still missing at the end of the run");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

/* src.f */
design/core_pkg.sv
design/pipe_reg.sv
design/operand_fetch.sv
design/hazard_ctrl.sv
design/exec_stage.sv
design/mem_stage.sv
design/backend_top.sv
verification/backend_assert.sv
verification/backend_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = backend_tb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
